/* logic/audio_params.svh */
// channel count, memory address width and DAC width defines
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// number of voice channels
`define AUDIO_NCHAN     4

`define AUDIO_ADDR_W    16      // memory word address bits

// DAC input width, one unsigned byte per side
`define AUDIO_DAC_W     8

`endif

/* logic/audio_pkg.sv */
// memory word, address, sample and volume types, and the sample word union
`include "audio_params.svh"

package audio_pkg;

    typedef logic [15:0]              word_t;      // one memory word
    typedef logic [`AUDIO_ADDR_W-1:0] addr_t;      // memory word address
    typedef logic signed [7:0]        sample_t;
    typedef logic [6:0]               vol_t;       // unsigned, 0..127

    // two samples packed in one memory word
    typedef struct packed {
        sample_t hi;                               // played first
        sample_t lo;
    } sample_pair_t;

    // memory side sees a raw word, the player sees two samples
    typedef union packed {
        word_t        raw;
        sample_pair_t pair;
    } sample_word_u;

endpackage

/* logic/audio_fetch_if.sv */
// fetch request and reply signals between one channel and the fetch arbiter
interface audio_fetch_if;
    import audio_pkg::*;

    logic  req;     // level, held until ack
    logic  tile;
    addr_t addr;    // stable while req is high
    logic  ack;     // one cycle, word valid here
    word_t word;

    // voice side
    modport chan (
        output req,
        output tile,
        output addr,
        input  ack,
        input  word
    );

    // arbiter side
    modport arb (
        input  req,
        input  tile,
        input  addr,
        output ack,
        output word
    );

endinterface

/* logic/audio_channel.sv */
// one voice: period counter, address and length stepping, two-sample word buffer
module audio_channel (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               enable_i,
    input  logic               tile_i,
    input  audio_pkg::addr_t   start_i,
    input  logic [14:0]        len_i,
    input  logic [14:0]        period_i,
    input  logic               restart_i,
    output logic               reload_o,
    output audio_pkg::sample_t sample_o,
    audio_fetch_if.chan        fetch
);
    import audio_pkg::*;

    logic [14:0]  period_q;     // cycles left until the next byte
    logic [15:0]  period_n;     // bit 15 flags the underflow
    logic [15:0]  len_q;        // words left before the wrap, minus one
    logic [15:0]  len_n;
    logic [15:0]  len_init;
    addr_t        addr_q;
    logic         tile_q;
    logic         req_q;
    logic         stale_q;      // pending fetch belongs to the old settings
    logic         full_q;       // buffered word holds unplayed bytes
    logic         half_q;       // high byte already played
    sample_word_u word_q;

    assign period_n = {1'b0, period_q} - 16'd1;
    assign len_n    = len_q - 16'd1;
    assign len_init = {1'b0, len_i} - 16'd1;   // len_i words per pass

    assign fetch.req  = req_q;
    assign fetch.tile = tile_q;
    assign fetch.addr = addr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_q <= '0;
            len_q    <= '0;
            addr_q   <= '0;
            tile_q   <= 1'b0;
            req_q    <= 1'b0;
            stale_q  <= 1'b0;
            full_q   <= 1'b0;
            half_q   <= 1'b0;
            reload_o <= 1'b0;
            sample_o <= '0;
        end else begin
            reload_o <= 1'b0;

            // fetch done, a stale reply is dropped and the request stays up
            if (fetch.ack) begin
                req_q   <= stale_q;
                stale_q <= 1'b0;
                full_q  <= !stale_q;
            end

            if (enable_i) begin
                period_q <= period_n[14:0];
                if (period_n[15]) begin
                    period_q <= period_i;
                    if (full_q) begin
                        sample_o <= half_q ? word_q.pair.lo : word_q.pair.hi;
                        half_q   <= !half_q;

                        // both bytes gone, step to the next word
                        if (half_q) begin
                            full_q <= 1'b0;
                            req_q  <= 1'b1;
                            if (len_n[15]) begin
                                addr_q   <= start_i;    // wrap to the start
                                tile_q   <= tile_i;
                                len_q    <= len_init;
                                reload_o <= 1'b1;
                            end else begin
                                addr_q <= addr_q + 1'b1;
                                len_q  <= len_n;
                            end
                        end
                    end
                end
            end else begin
                sample_o <= '0;     // silent while disabled
            end

            // restart wins over everything above
            if (restart_i) begin
                addr_q   <= start_i;
                tile_q   <= tile_i;
                len_q    <= len_init;
                period_q <= period_i;
                reload_o <= 1'b1;
                req_q    <= 1'b1;
                stale_q  <= req_q && !fetch.ack;
                full_q   <= 1'b0;
                half_q   <= 1'b0;
            end
        end
    end

    // word buffer
    always_ff @(posedge clk) begin
        if (fetch.ack) begin
            word_q.raw <= fetch.word;
        end
    end

endmodule

/* logic/audio_fetch_arbiter.sv */
// round-robin scan of channel fetch requests onto the single memory read port
`include "audio_params.svh"

module audio_fetch_arbiter (
    input  logic             clk,
    input  logic             reset_i,
    output logic             mem_fetch_o,
    output logic             mem_tile_o,
    output audio_pkg::addr_t mem_addr_o,
    input  logic             mem_ack_i,
    input  audio_pkg::word_t mem_word_i,
    audio_fetch_if.arb       chan [`AUDIO_NCHAN]
);
    import audio_pkg::*;

    localparam int NCHAN = `AUDIO_NCHAN;
    localparam int PTR_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    logic [PTR_W-1:0] ptr_q;        // visited channel, held while the port is busy
    logic [PTR_W-1:0] ptr_next;
    logic [NCHAN-1:0] req_v;
    logic [NCHAN-1:0] tile_v;
    addr_t            addr_v [NCHAN];
    logic             done;         // memory returned the word

    assign done     = mem_fetch_o && mem_ack_i;
    assign ptr_next = (ptr_q == PTR_W'(NCHAN - 1)) ? '0 : ptr_q + 1'b1;

    for (genvar i = 0; i < NCHAN; i++) begin : g_chan
        assign req_v[i]  = chan[i].req;
        assign tile_v[i] = chan[i].tile;
        assign addr_v[i] = chan[i].addr;

        // reply goes to the served channel only
        assign chan[i].ack  = done && (ptr_q == PTR_W'(i));
        assign chan[i].word = (ptr_q == PTR_W'(i)) ? mem_word_i : '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_fetch_o <= 1'b0;
            ptr_q       <= '0;
        end else if (mem_fetch_o) begin
            if (mem_ack_i) begin
                mem_fetch_o <= 1'b0;
                ptr_q       <= ptr_next;    // move on so the next voice gets a turn
            end
        end else if (req_v[ptr_q]) begin
            mem_fetch_o <= 1'b1;
        end else begin
            ptr_q <= ptr_next;              // idle scan, one channel per cycle
        end
    end

    // latch address and tile when a request is picked up
    always_ff @(posedge clk) begin
        if (!mem_fetch_o && req_v[ptr_q]) begin
            mem_tile_o <= tile_v[ptr_q];
            mem_addr_o <= addr_v[ptr_q];
        end
    end

endmodule

/* logic/audio_mix_core.sv */
// time-shared volume multiply, accumulate, saturate and unsigned conversion
`include "audio_params.svh"

module audio_mix_core (
    input  logic                    clk,
    input  logic                    reset_i,
    input  audio_pkg::sample_t      sample_i [`AUDIO_NCHAN],
    input  audio_pkg::vol_t         vol_l_i [`AUDIO_NCHAN],
    input  audio_pkg::vol_t         vol_r_i [`AUDIO_NCHAN],
    output logic [`AUDIO_DAC_W-1:0] out_l_o,
    output logic [`AUDIO_DAC_W-1:0] out_r_o
);
    import audio_pkg::*;

    localparam int NCHAN = `AUDIO_NCHAN;
    localparam int DAC_W = `AUDIO_DAC_W;
    localparam int CH_W  = (NCHAN > 1) ? $clog2(NCHAN) : 1;
    localparam int IDX_W = $clog2(NCHAN + 1);
    localparam int ACC_W = 16 + CH_W;      // headroom for all channels at full scale

    localparam logic [DAC_W-1:0] SILENCE = {1'b1, {(DAC_W - 1){1'b0}}};

    logic [IDX_W-1:0]        step_q;       // NCHAN is the saturate step
    logic                    last;
    logic [CH_W-1:0]         ch;
    sample_t                 smp;
    logic signed [15:0]      prod_l;
    logic signed [15:0]      prod_r;
    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;

    // sum >>> 6, clamp to the signed byte range, then offset to unsigned
    function automatic logic [DAC_W-1:0] to_dac(input logic signed [ACC_W-1:0] sum);
        logic signed [ACC_W-1:0] s;
        logic [ACC_W-DAC_W:0]    top;
        s   = sum >>> 6;
        top = s[ACC_W-1:DAC_W-1];
        if (&top || ~|top) begin
            return {~s[DAC_W-1], s[DAC_W-2:0]};
        end
        return s[ACC_W-1] ? '0 : '1;
    endfunction

    assign last = (step_q == IDX_W'(NCHAN));

    always_comb begin
        ch     = last ? '0 : step_q[CH_W-1:0];
        smp    = sample_i[ch];
        prod_l = smp * $signed({1'b0, vol_l_i[ch]});  // one multiplier per side
        prod_r = smp * $signed({1'b0, vol_r_i[ch]});
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            step_q  <= '0;
            out_l_o <= SILENCE;
            out_r_o <= SILENCE;
        end else if (last) begin
            step_q  <= '0;
            out_l_o <= to_dac(acc_l);
            out_r_o <= to_dac(acc_r);
        end else begin
            step_q <= step_q + 1'b1;
        end
    end

    // first channel starts a fresh sum
    always_ff @(posedge clk) begin
        if (!last) begin
            if (step_q == '0) begin
                acc_l <= ACC_W'(prod_l);
                acc_r <= ACC_W'(prod_r);
            end else begin
                acc_l <= acc_l + ACC_W'(prod_l);
                acc_r <= acc_r + ACC_W'(prod_r);
            end
        end
    end

endmodule

/* logic/audio_dac.sv */
// first-order pulse-density modulator for one output
`include "audio_params.svh"

module audio_dac (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`AUDIO_DAC_W-1:0] value_i,
    output logic                    pulse_o
);

    localparam int W = `AUDIO_DAC_W;

    logic [W:0] acc_q;      // top bit is the carry of the last add

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q   <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc_q   <= {1'b0, acc_q[W-1:0]} + {1'b0, value_i};
            pulse_o <= acc_q[W];    // one pulse per carry
        end
    end

endmodule

/* logic/audio_subsystem.sv */
// audio mixer top: voice channels, fetch arbiter, mix core and the two DACs
`include "audio_params.svh"

module audio_subsystem (
    input  logic                                 clk,
    input  logic                                 reset_i,

    // per-channel settings, channel i in slice i
    input  logic [`AUDIO_NCHAN-1:0]              enable_i,
    input  logic [7*`AUDIO_NCHAN-1:0]            vol_l_i,
    input  logic [7*`AUDIO_NCHAN-1:0]            vol_r_i,
    input  logic [15*`AUDIO_NCHAN-1:0]           period_i,
    input  logic [`AUDIO_NCHAN-1:0]              tile_i,
    input  logic [`AUDIO_ADDR_W*`AUDIO_NCHAN-1:0] start_i,
    input  logic [15*`AUDIO_NCHAN-1:0]           len_i,
    input  logic [`AUDIO_NCHAN-1:0]              restart_i,
    output logic [`AUDIO_NCHAN-1:0]              reload_o,

    // memory read port
    output logic                                 mem_fetch_o,
    output logic                                 mem_tile_o,
    output audio_pkg::addr_t                     mem_addr_o,
    input  logic                                 mem_ack_i,
    input  audio_pkg::word_t                     mem_word_i,

    output logic                                 pdm_l_o,
    output logic                                 pdm_r_o
);
    import audio_pkg::*;

    localparam int NCHAN  = `AUDIO_NCHAN;
    localparam int ADDR_W = `AUDIO_ADDR_W;

    audio_fetch_if fetch_if [NCHAN] ();

    sample_t                 chan_sample [NCHAN];
    vol_t                    vol_l [NCHAN];
    vol_t                    vol_r [NCHAN];
    logic [`AUDIO_DAC_W-1:0] mix_l;
    logic [`AUDIO_DAC_W-1:0] mix_r;

    for (genvar i = 0; i < NCHAN; i++) begin : g_chan
        assign vol_l[i] = vol_l_i[i*7 +: 7];
        assign vol_r[i] = vol_r_i[i*7 +: 7];

        audio_channel u_chan (
            .clk       (clk),
            .reset_i   (reset_i),
            .enable_i  (enable_i[i]),
            .tile_i    (tile_i[i]),
            .start_i   (start_i[i*ADDR_W +: ADDR_W]),
            .len_i     (len_i[i*15 +: 15]),
            .period_i  (period_i[i*15 +: 15]),
            .restart_i (restart_i[i]),
            .reload_o  (reload_o[i]),
            .sample_o  (chan_sample[i]),
            .fetch     (fetch_if[i])
        );
    end

    audio_fetch_arbiter u_arb (
        .clk         (clk),
        .reset_i     (reset_i),
        .mem_fetch_o (mem_fetch_o),
        .mem_tile_o  (mem_tile_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ack_i   (mem_ack_i),
        .mem_word_i  (mem_word_i),
        .chan        (fetch_if)
    );

    audio_mix_core u_mix (
        .clk      (clk),
        .reset_i  (reset_i),
        .sample_i (chan_sample),
        .vol_l_i  (vol_l),
        .vol_r_i  (vol_r),
        .out_l_o  (mix_l),
        .out_r_o  (mix_r)
    );

    // left and right pins
    audio_dac u_dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (mix_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac u_dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (mix_r),
        .pulse_o (pdm_r_o)
    );

endmodule

/* tests/audio_tb.sv */
// audio mixer testbench with clock, reset, memory model, reference model, checks and timeout
`include "audio_params.svh"

module audio_tb;
    import audio_pkg::*;

    localparam int NCHAN      = `AUDIO_NCHAN;
    localparam int ADDR_W     = `AUDIO_ADDR_W;
    localparam int PERIOD     = 1000;
    localparam int MAX_CYCLES = 40000;  // about twice the summed test windows

    logic clk;
    logic reset_i;
    logic [NCHAN-1:0]        enable_i;
    logic [7*NCHAN-1:0]      vol_l_i;
    logic [7*NCHAN-1:0]      vol_r_i;
    logic [15*NCHAN-1:0]     period_i;
    logic [NCHAN-1:0]        tile_i;
    logic [ADDR_W*NCHAN-1:0] start_i;
    logic [15*NCHAN-1:0]     len_i;
    logic [NCHAN-1:0]        restart_i;
    logic [NCHAN-1:0]        reload_o;
    logic  mem_fetch_o;
    logic  mem_tile_o;
    logic  mem_ack_i;
    logic  pdm_l_o;
    logic  pdm_r_o;
    addr_t mem_addr_o;
    word_t mem_word_i;

    // channel settings kept by the testbench
    vol_t        vl [NCHAN];
    vol_t        vr [NCHAN];
    addr_t       st [NCHAN];
    logic        tl [NCHAN];
    logic [14:0] ln [NCHAN];

    int    cyc = 0;
    int    errors = 0;
    int    req_cnt = 0;
    int    reload_cnt [NCHAN];
    int    reload_base [NCHAN];
    addr_t req_addr [$];
    logic  mem_busy = 1'b0;
    int    mem_delay = 0;
    int    win_left = 0;        // cycles left in the running PDM window
    int    exp_l;
    int    exp_r;
    int    ones_l;
    int    ones_r;
    int    t0;

    audio_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // byte that a channel plays as its j-th sample
    function automatic int byte_ref(input addr_t start, input logic tile,
                                    input logic [14:0] len, input int j);
        addr_t      a;
        logic [7:0] b;
        a = start + addr_t'((j / 2) % int'(len));
        if (j % 2 == 0) b = a[7:0];
        else            b = ~a[7:0] ^ {tile, 7'd0};
        return int'($signed(b));
    endfunction

    // sum of sample times volume, shifted right by 6, clamped and offset by 128
    function automatic int mix_ref(input int smp [NCHAN], input vol_t vol [NCHAN],
                                   input logic [NCHAN-1:0] en);
        int sum;
        int s;
        sum = 0;
        for (int i = 0; i < NCHAN; i++) begin
            if (en[i]) sum += smp[i] * int'(vol[i]);
        end
        s = sum >>> 6;
        if (s > 127)  s = 127;
        if (s < -128) s = -128;
        return s + 128;
    endfunction

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // memory model that acks after 0..5 cycles
    always @(negedge clk) begin
        if (mem_ack_i) begin
            mem_ack_i = 1'b0;
            mem_busy  = 1'b0;
        end else if (!reset_i && mem_fetch_o) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                mem_delay = $urandom_range(5, 0);
            end
            if (mem_delay == 0) begin
                mem_ack_i  = 1'b1;
                mem_word_i = {mem_addr_o[7:0], ~mem_addr_o[7:0] ^ {mem_tile_o, 7'd0}};
                req_addr.push_back(mem_addr_o);
                req_cnt++;
            end else begin
                mem_delay--;
            end
        end
    end

    always @(negedge clk) begin
        for (int i = 0; i < NCHAN; i++) begin
            if (reload_o[i]) reload_cnt[i]++;
        end
    end

    // PDM window counter and compare
    always @(negedge clk) begin
        if (win_left > 0) begin
            if (win_left == 256) begin
                ones_l = 0;
                ones_r = 0;
            end
            ones_l += int'(pdm_l_o);
            ones_r += int'(pdm_r_o);
            if (win_left == 1) begin
                if (ones_l < exp_l - 1 || ones_l > exp_l + 1) begin
                    $display("mismatch at %0t: left ones %0d, expected %0d",
                             $time, ones_l, exp_l);
                    errors++;
                end
                if (ones_r < exp_r - 1 || ones_r > exp_r + 1) begin
                    $display("mismatch at %0t: right ones %0d, expected %0d",
                             $time, ones_r, exp_r);
                    errors++;
                end
            end
            win_left <= win_left - 1;
        end
    end

    task automatic run_window(input int el, input int er);
        exp_l = el;
        exp_r = er;
        win_left <= 256;
        @(negedge clk);
        while (win_left != 0) @(negedge clk);
    endtask

    task automatic apply_settings(input logic [NCHAN-1:0] en);
        enable_i = en;
        for (int i = 0; i < NCHAN; i++) begin
            vol_l_i[i*7 +: 7]           = vl[i];
            vol_r_i[i*7 +: 7]           = vr[i];
            period_i[i*15 +: 15]        = 15'(PERIOD);
            tile_i[i]                   = tl[i];
            start_i[i*ADDR_W +: ADDR_W] = st[i];
            len_i[i*15 +: 15]           = ln[i];
        end
    endtask

    task automatic restart(input logic [NCHAN-1:0] mask);
        restart_i = mask;
        @(negedge clk);
        restart_i = '0;
        t0 = cyc;
    endtask

    // check bytes k_first..k_last with each window well inside its sample
    task automatic play_check(input int k_first, input int k_last);
        int smp [NCHAN];
        for (int k = k_first; k <= k_last; k++) begin
            while (cyc < t0 + k * (PERIOD + 1) + 200) @(negedge clk);
            for (int i = 0; i < NCHAN; i++) smp[i] = byte_ref(st[i], tl[i], ln[i], k - 1);
            run_window(mix_ref(smp, vl, enable_i), mix_ref(smp, vr, enable_i));
        end
    endtask

    initial begin
        void'($urandom(32'ha96c));
        reset_i = 1'b1;
        restart_i = '0;
        mem_ack_i = 1'b0;
        mem_word_i = '0;
        for (int i = 0; i < NCHAN; i++) begin
            vl[i] = '0;
            vr[i] = '0;
            st[i] = '0;
            tl[i] = 1'b0;
            ln[i] = 15'd1;
            reload_cnt[i] = 0;
        end
        apply_settings('0);
        repeat (16) @(negedge clk);
        reset_i = 1'b0;

        // reset and silence
        repeat (64) begin
            @(negedge clk);
            if (mem_fetch_o || reload_o != '0) begin
                $display("mismatch at %0t: fetch or reload active while all channels are idle",
                         $time);
                errors++;
            end
        end
        run_window(128, 128);
        run_window(128, 128);
        if (req_addr.size() != 0) begin
            $display("mismatch at %0t: %0d memory requests before any restart",
                     $time, req_addr.size());
            errors++;
        end

        // channel 0 alone for addressing and length wrap
        vl[0] = 7'd64;
        vr[0] = 7'd32;
        st[0] = 16'h0100;
        ln[0] = 15'd4;
        apply_settings(4'b0001);
        restart(4'b0001);
        play_check(1, 10);
        if (req_addr.size() != 6) begin
            $display("mismatch at %0t: channel 0 made %0d memory requests, expected 6",
                     $time, req_addr.size());
            errors++;
        end
        foreach (req_addr[i]) begin
            if (req_addr[i] != st[0] + addr_t'(i % int'(ln[0]))) begin
                $display("mismatch at %0t: request %0d address %h", $time, i, req_addr[i]);
                errors++;
            end
        end
        if (reload_cnt[0] != 2) begin
            $display("mismatch at %0t: channel 0 gave %0d reload pulses, expected 2",
                     $time, reload_cnt[0]);
            errors++;
        end

        // all channels sharing the memory port
        st = '{16'h0210, 16'h0320, 16'h0430, 16'h05f0};
        tl = '{1'b1, 1'b0, 1'b1, 1'b0};
        ln = '{15'd3, 15'd2, 15'd5, 15'd3};
        vl = '{7'd20, 7'd15, 7'd10, 7'd5};
        vr = '{7'd5, 7'd10, 7'd15, 7'd20};
        apply_settings('1);
        reload_base = reload_cnt;
        restart('1);
        play_check(1, 6);

        // one pulse for the restart and one per finished pass of three played words
        for (int i = 0; i < NCHAN; i++) begin
            if (reload_cnt[i] - reload_base[i] != 1 + 3 / int'(ln[i])) begin
                $display("mismatch at %0t: channel %0d gave %0d reload pulses, expected %0d",
                         $time, i, reload_cnt[i] - reload_base[i], 1 + 3 / int'(ln[i]));
                errors++;
            end
        end

        // saturation at full volume and then two channels disabled
        for (int i = 0; i < NCHAN; i++) begin
            st[i] = 16'h007f;
            tl[i] = 1'b0;
            ln[i] = 15'd1;
            vl[i] = 7'd127;
            vr[i] = 7'd127;
        end
        apply_settings('1);
        restart('1);
        play_check(1, 2);
        vl[0] = 7'd20;
        vr[0] = 7'd20;
        vl[1] = 7'd20;
        vr[1] = 7'd20;
        apply_settings(4'b0011);
        play_check(3, 4);

        $display("errors %0d, memory requests %0d, reload pulses ch0 %0d",
                 errors, req_cnt, reload_cnt[0]);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/audio_pkg.sv
logic/audio_fetch_if.sv
logic/audio_channel.sv
logic/audio_fetch_arbiter.sv
logic/audio_mix_core.sv
logic/audio_dac.sv
logic/audio_subsystem.sv
tests/audio_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= audio_tb
BUILD     ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
